//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_cmd_processor
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- flist.f
source/cmd_pkg.sv
source/spi_sequencer.sv
source/cmd_decode.sv
source/reply_tx.sv
source/cmd_execute.sv
source/cmd_processor.sv
test/tb_cmd_processor.sv

//--- source/cmd_decode.sv
// command decoder
// collects 8 stream bytes, issues the boot command once after reset
// and hands known commands on to the executer

`timescale 1ns/1ps

module cmd_decode (
	input  logic           clk,
	input  logic           rstn,
	input  logic           i_tvalid,
	input  logic [7:0]     i_tdata,
	input  logic           i_reply_done,
	output logic           o_tready,
	output cmd_pkg::cmd_t  o_cmd,
	output logic           o_cmd_valid,
	output logic           o_cmd_boot
);
	import cmd_pkg::*;

	// spi to chip 0, bytes 00 02 03 powers the adc down
	localparam cmd_t BOOT_CMD = '{
		op:  OP_SPI,
		arg: {8'h03, 8'h00, 8'h00, 8'h03, 8'h02, 8'h00, 8'h00}
	};

	rx_state_e                  state;
	logic [2:0]                 byte_cnt;
	logic [CMD_BYTES-1:0][7:0]  rx_q;
	logic                       boot_q;
	logic                       op_known;

	assign o_tready = (state == RX_COLLECT);
	assign op_known = boot_q || (rx_q[0] inside {OP_INFO, OP_SPI, OP_SPI_MODE, OP_TRIG_SET});
	assign o_cmd_valid = (state == RX_ISSUE) && op_known;
	assign o_cmd_boot  = boot_q;

	always_comb begin
		if (boot_q) begin
			o_cmd = BOOT_CMD;
		end else begin
			o_cmd.op  = cmd_op_e'(rx_q[0]);
			o_cmd.arg = rx_q[7:1];
		end
	end

	// ------------------------------------------------------------
	// receive / issue / wait
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state    <= RX_ISSUE;               // boot command goes first
			boot_q   <= 1'b1;
			byte_cnt <= '0;
		end else begin
			case (state)
				RX_COLLECT: begin
					if (i_tvalid) begin
						byte_cnt <= byte_cnt + 3'd1;  // wraps after last byte
						if (byte_cnt == 3'(CMD_BYTES - 1))
							state <= RX_ISSUE;
					end
				end
				RX_ISSUE: begin
					boot_q <= 1'b0;
					state  <= op_known ? RX_WAIT : RX_COLLECT;  // unknown is dropped
				end
				RX_WAIT: begin
					if (i_reply_done)
						state <= RX_COLLECT;
				end
				default: state <= RX_COLLECT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (o_tready && i_tvalid)
			rx_q[byte_cnt] <= i_tdata;
	end

	// input stays closed from issue until the reply has gone out
	a_no_rx_while_busy: assert property (@(posedge clk) disable iff (!rstn)
		o_cmd_valid |=> (!o_tready until i_reply_done));

endmodule

//--- source/cmd_execute.sv
// command executer
// info, spi mode and trigger commands, overrange counting,
// spi transactions through the sequencer, reply word select

`timescale 1ns/1ps

module cmd_execute #(
	parameter int VERSION         = 16,
	parameter int CS_SETUP_CYCLES = 10,
	parameter int CS_HOLD_CYCLES  = 35
) (
	input  logic                clk,
	input  logic                rstn,
	input  cmd_pkg::cmd_t       i_cmd,
	input  logic                i_cmd_valid,
	input  logic                i_cmd_boot,
	input  logic [7:0]          i_board_id,
	input  logic [3:0]          i_overrange,
	input  logic                i_spi_tx_ready,
	input  logic                i_spi_rx_dv,
	input  logic [7:0]          i_spi_rx_byte,
	output cmd_pkg::reply_t     o_reply,
	output logic                o_boot_done,
	output cmd_pkg::trig_cfg_t  o_trig_cfg,
	output logic [1:0]          o_spi_mode,
	output logic                o_spi_reset_n,
	output logic [7:0]          o_spi_tx_byte,
	output logic                o_spi_tx_dv,
	output logic [7:0]          o_spi_cs_n,
	output logic [2:0]          o_spi_miso_sel
);
	import cmd_pkg::*;

	logic [3:0][REPLY_W-1:0]  ovr_cnt;
	logic                     boot_q;           // current command is the boot one
	logic                     spi_start;
	logic                     spi_done;
	logic [REPLY_W-1:0]       spi_rx_word;
	logic [REPLY_W-1:0]       info_word;
	logic [11:0]              lower_thr;
	logic [11:0]              upper_thr;
	logic                     reply_ev;

	assign spi_start = i_cmd_valid && (i_cmd.op == OP_SPI);

	// adc codes from level and hysteresis
	assign lower_thr = (({4'd0, i_cmd.arg[1]} - {4'd0, i_cmd.arg[2]} - 12'd128) << 4) + 12'd8;
	assign upper_thr = (({4'd0, i_cmd.arg[1]} + {4'd0, i_cmd.arg[2]} - 12'd128) << 4) + 12'd8;

	always_comb begin
		case (i_cmd.arg[1])
			8'd0:    info_word = REPLY_W'(VERSION);
			8'd1:    info_word = {4{i_board_id}};
			8'd2:    info_word = ovr_cnt[i_cmd.arg[2][1:0]];
			default: info_word = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			ovr_cnt <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (i_overrange[i])
					ovr_cnt[i] <= ovr_cnt[i] + 32'd1;  // cycles spent in overrange
			end
		end
	end

	// ------------------------------------------------------------
	// command execution
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_reply       <= '0;
			o_boot_done   <= 1'b0;
			boot_q        <= 1'b0;
			o_trig_cfg    <= '0;
			o_spi_mode    <= '0;
			o_spi_reset_n <= 1'b1;
		end else begin
			o_reply.valid <= 1'b0;
			o_boot_done   <= 1'b0;
			o_spi_reset_n <= 1'b1;
			if (i_cmd_valid) begin
				boot_q <= i_cmd_boot;
				case (i_cmd.op)
					OP_INFO: begin
						o_reply.valid <= 1'b1;
						o_reply.data  <= info_word;
					end
					OP_SPI_MODE: begin
						o_spi_mode    <= i_cmd.arg[1][1:0];
						o_spi_reset_n <= 1'b0;          // one cycle reset pulse
						o_reply.valid <= 1'b1;
						o_reply.data  <= {24'd0, i_cmd.arg[1]};
					end
					OP_TRIG_SET: begin
						o_trig_cfg.lower  <= lower_thr;
						o_trig_cfg.upper  <= upper_thr;
						o_trig_cfg.offset <= {i_cmd.arg[3][1:0], i_cmd.arg[4]};
						o_reply.valid     <= 1'b1;
						o_reply.data      <= TRIG_ACK;
					end
					default: ;                          // spi answers when the sequencer is done
				endcase
			end
			if (spi_done) begin
				o_reply.valid <= !boot_q;             // boot answer is swallowed
				o_reply.data  <= spi_rx_word;
				o_boot_done   <= boot_q;
			end
		end
	end

	spi_sequencer #(
		.CS_SETUP_CYCLES (CS_SETUP_CYCLES),
		.CS_HOLD_CYCLES  (CS_HOLD_CYCLES)
	) spi_sequencer_i (
		.clk            (clk),
		.rstn           (rstn),
		.i_start        (spi_start),
		.i_cmd          (i_cmd),
		.i_spi_tx_ready (i_spi_tx_ready),
		.i_spi_rx_dv    (i_spi_rx_dv),
		.i_spi_rx_byte  (i_spi_rx_byte),
		.o_done         (spi_done),
		.o_rx_word      (spi_rx_word),
		.o_spi_tx_byte  (o_spi_tx_byte),
		.o_spi_tx_dv    (o_spi_tx_dv),
		.o_spi_cs_n     (o_spi_cs_n),
		.o_spi_miso_sel (o_spi_miso_sel)
	);

	// one answer per command at most, boot answer included
	assign reply_ev = o_reply.valid | o_boot_done;

	a_one_reply: assert property (@(posedge clk) disable iff (!rstn)
		reply_ev |=> (!reply_ev until i_cmd_valid));

endmodule

//--- source/cmd_pkg.sv
// command processor shared types
// opcodes, state encodings, command, trigger and reply structs

package cmd_pkg;

	localparam int CMD_BYTES = 8;             // bytes per command
	localparam int REPLY_W   = 32;            // reply word width

	localparam logic [REPLY_W-1:0] TRIG_ACK = 32'd37; // trigger settings answer

	// ------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------
	typedef enum logic [7:0] {
		OP_INFO     = 8'd2,                   // version, board id, overrange
		OP_SPI      = 8'd3,                   // spi transaction
		OP_SPI_MODE = 8'd4,                   // spi mode and reset
		OP_TRIG_SET = 8'd8                    // trigger thresholds
	} cmd_op_e;

	typedef enum logic [2:0] {
		SPI_IDLE,
		SPI_SETUP,                            // cs low, settle
		SPI_SEND,                             // wait for tx_ready
		SPI_GAP,                              // strobe out, next byte
		SPI_WAIT_RX,
		SPI_HOLD                              // cs still low
	} spi_state_e;

	typedef enum logic [1:0] {
		RX_COLLECT,
		RX_ISSUE,
		RX_WAIT
	} rx_state_e;

	// ------------------------------------------------------------
	// structs
	// ------------------------------------------------------------
	typedef struct packed {
		cmd_op_e          op;                 // byte 0
		logic [7:1][7:0]  arg;                // bytes 1..7
	} cmd_t;

	typedef struct packed {
		logic signed [11:0] lower;
		logic signed [11:0] upper;
		logic [9:0]         offset;           // pre-trigger samples
	} trig_cfg_t;

	typedef struct packed {
		logic               valid;            // one cycle strobe
		logic [REPLY_W-1:0] data;
	} reply_t;

endpackage

//--- source/cmd_processor.sv
// command processor top level
// byte stream in, one reply word per known command out

`timescale 1ns/1ps

module cmd_processor #(
	parameter int VERSION         = 16,
	parameter int CS_SETUP_CYCLES = 10,
	parameter int CS_HOLD_CYCLES  = 35
) (
	input  logic                        clk,
	input  logic                        rstn,
	// command byte stream
	input  logic                        i_tvalid,
	input  logic [7:0]                  i_tdata,
	output logic                        o_tready,
	// reply stream
	input  logic                        i_m_tready,
	output logic                        o_m_tvalid,
	output logic [cmd_pkg::REPLY_W-1:0] o_m_tdata,
	output logic [3:0]                  o_m_tkeep,
	output logic                        o_m_tlast,
	// spi master
	input  logic                        i_spi_tx_ready,
	input  logic                        i_spi_rx_dv,
	input  logic [7:0]                  i_spi_rx_byte,
	output logic [7:0]                  o_spi_tx_byte,
	output logic                        o_spi_tx_dv,
	output logic [7:0]                  o_spi_cs_n,
	output logic [2:0]                  o_spi_miso_sel,
	output logic [1:0]                  o_spi_mode,
	output logic                        o_spi_reset_n,
	// board
	input  logic [7:0]                  i_board_id,
	input  logic [3:0]                  i_overrange,
	output cmd_pkg::trig_cfg_t          o_trig_cfg
);
	import cmd_pkg::*;

	cmd_t    cmd;
	logic    cmd_valid;
	logic    cmd_boot;
	reply_t  reply;
	logic    tx_done;
	logic    boot_done;
	logic    reply_done;

	assign reply_done = tx_done | boot_done;    // boot command finishes without a reply

	cmd_decode cmd_decode_i (
		.clk          (clk),
		.rstn         (rstn),
		.i_tvalid     (i_tvalid),
		.i_tdata      (i_tdata),
		.i_reply_done (reply_done),
		.o_tready     (o_tready),
		.o_cmd        (cmd),
		.o_cmd_valid  (cmd_valid),
		.o_cmd_boot   (cmd_boot)
	);

	cmd_execute #(
		.VERSION         (VERSION),
		.CS_SETUP_CYCLES (CS_SETUP_CYCLES),
		.CS_HOLD_CYCLES  (CS_HOLD_CYCLES)
	) cmd_execute_i (
		.clk            (clk),
		.rstn           (rstn),
		.i_cmd          (cmd),
		.i_cmd_valid    (cmd_valid),
		.i_cmd_boot     (cmd_boot),
		.i_board_id     (i_board_id),
		.i_overrange    (i_overrange),
		.i_spi_tx_ready (i_spi_tx_ready),
		.i_spi_rx_dv    (i_spi_rx_dv),
		.i_spi_rx_byte  (i_spi_rx_byte),
		.o_reply        (reply),
		.o_boot_done    (boot_done),
		.o_trig_cfg     (o_trig_cfg),
		.o_spi_mode     (o_spi_mode),
		.o_spi_reset_n  (o_spi_reset_n),
		.o_spi_tx_byte  (o_spi_tx_byte),
		.o_spi_tx_dv    (o_spi_tx_dv),
		.o_spi_cs_n     (o_spi_cs_n),
		.o_spi_miso_sel (o_spi_miso_sel)
	);

	reply_tx reply_tx_i (
		.clk        (clk),
		.rstn       (rstn),
		.i_reply    (reply),
		.i_m_tready (i_m_tready),
		.o_m_tvalid (o_m_tvalid),
		.o_m_tdata  (o_m_tdata),
		.o_m_tkeep  (o_m_tkeep),
		.o_m_tlast  (o_m_tlast),
		.o_done     (tx_done)
	);

endmodule

//--- source/reply_tx.sv
// reply transmitter
// holds one reply word on the output stream until the bridge takes it

`timescale 1ns/1ps

module reply_tx (
	input  logic                        clk,
	input  logic                        rstn,
	input  cmd_pkg::reply_t             i_reply,
	input  logic                        i_m_tready,
	output logic                        o_m_tvalid,
	output logic [cmd_pkg::REPLY_W-1:0] o_m_tdata,
	output logic [3:0]                  o_m_tkeep,
	output logic                        o_m_tlast,
	output logic                        o_done
);

	assign o_m_tkeep = '1;                      // always a full word
	assign o_m_tlast = 1'b1;                    // single beat replies

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_m_tvalid <= 1'b0;
			o_done     <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_reply.valid) begin
				o_m_tvalid <= 1'b1;
			end else if (o_m_tvalid && i_m_tready) begin
				o_m_tvalid <= 1'b0;
				o_done     <= 1'b1;             // word accepted
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_reply.valid)
			o_m_tdata <= i_reply.data;
	end

endmodule

//--- source/spi_sequencer.sv
// spi transaction sequencer
// chip select, setup wait, 2 to 4 byte strobes to the spi master,
// read byte capture and chip select hold

`timescale 1ns/1ps

module spi_sequencer #(
	parameter int CS_SETUP_CYCLES = 10,
	parameter int CS_HOLD_CYCLES  = 35
) (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        i_start,
	input  cmd_pkg::cmd_t               i_cmd,
	input  logic                        i_spi_tx_ready,
	input  logic                        i_spi_rx_dv,
	input  logic [7:0]                  i_spi_rx_byte,
	output logic                        o_done,
	output logic [cmd_pkg::REPLY_W-1:0] o_rx_word,
	output logic [7:0]                  o_spi_tx_byte,
	output logic                        o_spi_tx_dv,
	output logic [7:0]                  o_spi_cs_n,
	output logic [2:0]                  o_spi_miso_sel
);
	import cmd_pkg::*;

	spi_state_e   state;
	cmd_t         cmd_q;
	logic [15:0]  wait_cnt;
	logic [2:0]   byte_idx;                     // argument byte being sent
	logic [2:0]   last_idx;
	logic [2:0]   start_cnt;                    // clamped byte count
	logic [7:0]   rx_q;

	always_comb begin
		if (i_cmd.arg[7] < 8'd2)
			start_cnt = 3'd2;
		else if (i_cmd.arg[7] > 8'd4)
			start_cnt = 3'd4;
		else
			start_cnt = i_cmd.arg[7][2:0];
	end

	assign o_rx_word = {{(REPLY_W - 8){1'b0}}, rx_q};

	always_ff @(posedge clk) begin
		if (i_start)
			cmd_q <= i_cmd;
		if (state == SPI_WAIT_RX && i_spi_rx_dv)
			rx_q <= i_spi_rx_byte;
	end

	// ------------------------------------------------------------
	// transaction fsm
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= SPI_IDLE;
			wait_cnt       <= '0;
			byte_idx       <= '0;
			last_idx       <= '0;
			o_done         <= 1'b0;
			o_spi_tx_byte  <= '0;
			o_spi_tx_dv    <= 1'b0;
			o_spi_cs_n     <= '1;
			o_spi_miso_sel <= '0;
		end else begin
			o_spi_tx_dv <= 1'b0;
			o_done      <= 1'b0;
			case (state)
				SPI_IDLE: begin
					if (i_start) begin
						o_spi_cs_n[i_cmd.arg[1][2:0]] <= 1'b0;
						o_spi_miso_sel <= i_cmd.arg[1][2:0];
						byte_idx       <= 3'd2;
						last_idx       <= start_cnt + 3'd1;
						wait_cnt       <= '0;
						state          <= SPI_SETUP;
					end
				end
				SPI_SETUP: begin
					if (wait_cnt == 16'(CS_SETUP_CYCLES - 1)) begin
						wait_cnt <= '0;
						state    <= SPI_SEND;
					end else begin
						wait_cnt <= wait_cnt + 16'd1;
					end
				end
				SPI_SEND: begin
					if (i_spi_tx_ready) begin
						o_spi_tx_byte <= cmd_q.arg[byte_idx];
						o_spi_tx_dv   <= 1'b1;
						state         <= SPI_GAP;
					end
				end
				SPI_GAP: begin
					if (byte_idx == last_idx) begin
						state <= SPI_WAIT_RX;
					end else begin
						byte_idx <= byte_idx + 3'd1;
						state    <= SPI_SEND;
					end
				end
				SPI_WAIT_RX: begin
					if (i_spi_rx_dv)
						state <= SPI_HOLD;
				end
				SPI_HOLD: begin
					if (wait_cnt == 16'(CS_HOLD_CYCLES - 1)) begin
						wait_cnt   <= '0;
						o_spi_cs_n <= '1;               // release all chips
						o_done     <= 1'b1;
						state      <= SPI_IDLE;
					end else begin
						wait_cnt <= wait_cnt + 16'd1;
					end
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	a_tx_when_ready: assert property (@(posedge clk) disable iff (!rstn)
		o_spi_tx_dv |-> i_spi_tx_ready);

endmodule

//--- test/cmd_stim.txt
// columns: 8 command bytes (opcode first) | spi response | stall cycles | expected reply
// info sub-code 2 holds the overrange bit named by byte 2 high for expected-reply cycles
02 00 00 00 00 00 00 00  00 00 00000010
02 01 00 00 00 00 00 00  00 02 5a5a5a5a
02 02 01 00 00 00 00 00  00 01 0000000c
02 02 03 00 00 00 00 00  00 00 00000005
// spi transactions with 2, 3 and 4 bytes
03 02 a1 b2 00 00 00 02  c3 00 000000c3
03 05 11 22 33 00 00 03  7e 03 0000007e
03 07 de ad be ef 00 04  81 01 00000081
// trigger settings, level and hysteresis in bytes 1 and 2
08 a0 10 02 34 00 00 00  00 00 00000025
08 60 08 01 ff 00 00 00  00 02 00000025
// mode set under back-pressure, unknown opcode, mode set again
04 02 00 00 00 00 00 00  00 04 00000002
55 00 00 00 00 00 00 00  00 00 00000000
04 01 00 00 00 00 00 00  00 00 00000001

//--- test/tb_cmd_processor.sv
// testbench for the command processor
// stim file driven commands, spi master model, reply and side output checks

`timescale 1ns/1ps

module tb_cmd_processor;
	import cmd_pkg::*;

	localparam int LINE_W    = 11;              // words per stim line
	localparam int MAX_LINES = 32;

	logic        clk = 1'b0;
	logic        rstn;
	logic        i_tvalid;
	logic [7:0]  i_tdata;
	logic        o_tready;
	logic        i_m_tready;
	logic        o_m_tvalid;
	logic [31:0] o_m_tdata;
	logic [3:0]  o_m_tkeep;
	logic        o_m_tlast;
	logic        i_spi_tx_ready;
	logic        i_spi_rx_dv;
	logic [7:0]  i_spi_rx_byte;
	logic [7:0]  o_spi_tx_byte;
	logic        o_spi_tx_dv;
	logic [7:0]  o_spi_cs_n;
	logic [2:0]  o_spi_miso_sel;
	logic [1:0]  o_spi_mode;
	logic        o_spi_reset_n;
	logic [7:0]  i_board_id;
	logic [3:0]  i_overrange;
	trig_cfg_t   o_trig_cfg;

	logic [31:0] stim [LINE_W*MAX_LINES];
	int          n_lines;
	int          limit;
	int          cycles;
	int          errors;
	int          tests;
	int          failed_tests;
	int          valid_cycles;                  // cycles with o_m_tvalid high
	int          reset_low_cycles;

	// spi master model state, set up per test
	logic [7:0]  spi_rx_q [$];
	logic [2:0]  spi_chip;
	int          spi_cnt;
	logic [7:0]  spi_resp;

	always #10 clk = ~clk;

	cmd_processor #(
		.VERSION         (16),
		.CS_SETUP_CYCLES (10),
		.CS_HOLD_CYCLES  (35)
	) cmd_processor_i (
		.clk            (clk),
		.rstn           (rstn),
		.i_tvalid       (i_tvalid),
		.i_tdata        (i_tdata),
		.o_tready       (o_tready),
		.i_m_tready     (i_m_tready),
		.o_m_tvalid     (o_m_tvalid),
		.o_m_tdata      (o_m_tdata),
		.o_m_tkeep      (o_m_tkeep),
		.o_m_tlast      (o_m_tlast),
		.i_spi_tx_ready (i_spi_tx_ready),
		.i_spi_rx_dv    (i_spi_rx_dv),
		.i_spi_rx_byte  (i_spi_rx_byte),
		.o_spi_tx_byte  (o_spi_tx_byte),
		.o_spi_tx_dv    (o_spi_tx_dv),
		.o_spi_cs_n     (o_spi_cs_n),
		.o_spi_miso_sel (o_spi_miso_sel),
		.o_spi_mode     (o_spi_mode),
		.o_spi_reset_n  (o_spi_reset_n),
		.i_board_id     (i_board_id),
		.i_overrange    (i_overrange),
		.o_trig_cfg     (o_trig_cfg)
	);

	task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic int clamp_count(input logic [7:0] cnt);
		if (cnt < 8'd2)
			return 2;
		if (cnt > 8'd4)
			return 4;
		return int'(cnt);
	endfunction

	// adc code for level plus a signed hysteresis step
	function automatic logic [11:0] trig_threshold(input int level, input int hyst);
		int v;
		v = (level + hyst - 128) * 16 + 8;
		return v[11:0];
	endfunction

	// ------------------------------------------------------------
	// monitors and run limit
	// ------------------------------------------------------------
	always @(posedge clk) begin
		cycles++;
		if (o_m_tvalid)
			valid_cycles++;
		if (!o_spi_reset_n)
			reset_low_cycles++;
		if (cycles >= limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// spi master: ready drops 3 cycles per strobe, answer one cycle after last byte
	initial begin : spi_master_model
		int busy;
		int resp_delay;
		busy          = 0;
		resp_delay    = 0;
		i_spi_tx_ready = 1'b1;
		i_spi_rx_dv    = 1'b0;
		i_spi_rx_byte  = 8'h00;
		forever begin
			@(posedge clk);
			if (busy > 0)
				busy--;
			if (resp_delay > 0)
				resp_delay--;
			if (o_spi_tx_dv) begin
				spi_rx_q.push_back(o_spi_tx_byte);
				compare_values({24'd0, o_spi_cs_n}, {24'd0, ~(8'd1 << spi_chip)},
					"chip select at spi strobe");
				compare_values({29'd0, o_spi_miso_sel}, {29'd0, spi_chip}, "miso select");
				busy = 3;
				if (spi_rx_q.size() == spi_cnt)
					resp_delay = 1;
			end
			#2;
			i_spi_tx_ready = (busy == 0);
			i_spi_rx_dv    = (resp_delay == 1);
			i_spi_rx_byte  = spi_resp;
		end
	end

	// ------------------------------------------------------------
	// stimulus tasks, all entered and left 2 ns after an edge
	// ------------------------------------------------------------
	task automatic send_command(input logic [7:0] b [8]);
		for (int i = 0; i < 8; i++) begin
			i_tvalid = 1'b1;
			i_tdata  = b[i];
			@(posedge clk);
			while (!o_tready)
				@(posedge clk);
			#2;
		end
		i_tvalid = 1'b0;
	endtask

	task automatic take_reply(input int stall, output logic [31:0] data);
		logic [31:0] held;
		@(posedge clk);
		while (!o_m_tvalid)
			@(posedge clk);
		held = o_m_tdata;
		repeat (stall) begin
			#2;
			i_m_tready = 1'b0;
			@(posedge clk);
			compare_values({31'd0, o_m_tvalid}, 32'd1, "tvalid under back-pressure");
			compare_values(o_m_tdata, held, "tdata under back-pressure");
		end
		#2;
		i_m_tready = 1'b1;
		@(posedge clk);
		compare_values({31'd0, o_m_tvalid}, 32'd1, "tvalid at accept");
		compare_values(o_m_tdata, held, "tdata at accept");
		compare_values({28'd0, o_m_tkeep}, 32'hf, "tkeep");
		compare_values({31'd0, o_m_tlast}, 32'd1, "tlast");
		#2;
		i_m_tready = 1'b0;
		data = held;
	endtask

	task automatic hold_overrange(input logic [1:0] idx, input int n);
		i_overrange[idx] = 1'b1;
		repeat (n) @(posedge clk);
		#2;
		i_overrange[idx] = 1'b0;
	endtask

	task automatic run_line(input int line);
		logic [7:0]  b [8];
		logic [31:0] exp;
		logic [31:0] got;
		int          stall;
		int          err_before;
		int          valid_before;
		int          rst_before;
		for (int i = 0; i < 8; i++)
			b[i] = stim[line*LINE_W + i][7:0];
		spi_resp     = stim[line*LINE_W + 8][7:0];
		stall        = int'(stim[line*LINE_W + 9]);
		exp          = stim[line*LINE_W + 10];
		err_before   = errors;
		valid_before = valid_cycles;
		rst_before   = reset_low_cycles;
		if (b[0] == 8'd2 && b[1] == 8'd2)
			hold_overrange(b[2][1:0], int'(exp));  // counter must read back n
		if (b[0] == 8'd3) begin
			spi_chip = b[1][2:0];
			spi_cnt  = clamp_count(b[7]);
			spi_rx_q.delete();
		end
		send_command(b);
		if (b[0] inside {OP_INFO, OP_SPI, OP_SPI_MODE, OP_TRIG_SET}) begin
			take_reply(stall, got);
			compare_values(got, exp, "reply word");
			if (b[0] == 8'd3) begin
				compare_values(spi_rx_q.size(), spi_cnt, "spi byte count");
				for (int k = 0; k < spi_cnt && k < spi_rx_q.size(); k++)
					compare_values({24'd0, spi_rx_q[k]}, {24'd0, b[2+k]}, "spi byte");
				compare_values({24'd0, o_spi_cs_n}, 32'hff, "chip selects released");
			end
			if (b[0] == 8'd4) begin
				compare_values({30'd0, o_spi_mode}, {30'd0, b[1][1:0]}, "spi mode");
				compare_values(reset_low_cycles, rst_before + 1, "spi reset pulse");
			end
			if (b[0] == 8'd8) begin
				compare_values({20'd0, o_trig_cfg.lower},
					{20'd0, trig_threshold(int'(b[1]), -int'(b[2]))}, "lower threshold");
				compare_values({20'd0, o_trig_cfg.upper},
					{20'd0, trig_threshold(int'(b[1]), int'(b[2]))}, "upper threshold");
				compare_values({22'd0, o_trig_cfg.offset}, {22'd0, b[3][1:0], b[4]},
					"pre-trigger offset");
			end
		end else begin
			@(posedge clk);
			while (!o_tready)
				@(posedge clk);
			repeat (20) @(posedge clk);           // long enough for any late reply
			#2;
			compare_values(valid_cycles, valid_before, "reply to unknown opcode");
		end
		tests++;
		if (errors != err_before)
			failed_tests++;
		$display("test %0d opcode %02h: %s", tests, b[0],
			(errors == err_before) ? "ok" : "mismatch");
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin : main
		int err_before;
		rstn        = 1'b0;
		i_tvalid    = 1'b0;
		i_tdata     = 8'h00;
		i_m_tready  = 1'b0;
		i_board_id  = 8'h5a;
		i_overrange = 4'h0;
		spi_chip    = 3'd0;                       // boot command goes to chip 0
		spi_cnt     = 3;
		spi_resp    = 8'h00;
		for (int i = 0; i < LINE_W*MAX_LINES; i++)
			stim[i] = 32'hdead_0000 | 32'(i);      // above any byte value
		$readmemh("test/cmd_stim.txt", stim);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim[n_lines*LINE_W] <= 32'h0000_00ff)
			n_lines++;
		limit = n_lines * 200 + 500;
		if (n_lines == 0) begin
			$display("stimulus file test/cmd_stim.txt holds no commands");
			errors++;
		end

		repeat (4) @(posedge clk);
		compare_values({31'd0, o_m_tvalid}, 32'd0, "tvalid in reset");
		compare_values({31'd0, o_tready}, 32'd0, "tready in reset");
		compare_values({24'd0, o_spi_cs_n}, 32'hff, "chip selects in reset");
		compare_values({31'd0, o_spi_tx_dv}, 32'd0, "spi strobe in reset");
		compare_values({31'd0, o_spi_reset_n}, 32'd1, "spi reset_n in reset");
		compare_values({31'd0, o_trig_cfg == '0}, 32'd1, "trigger config in reset");
		#2;
		rstn = 1'b1;

		// boot command, adc power down without a reply
		err_before = errors;
		@(posedge clk);
		while (o_spi_cs_n == 8'hff)
			@(posedge clk);
		compare_values({24'd0, o_spi_cs_n}, 32'hfe, "boot chip select");
		while (o_spi_cs_n != 8'hff)
			@(posedge clk);
		while (!o_tready)
			@(posedge clk);
		#2;
		compare_values(spi_rx_q.size(), 3, "boot byte count");
		if (spi_rx_q.size() == 3) begin
			compare_values({24'd0, spi_rx_q[0]}, 32'h00, "boot byte 0");
			compare_values({24'd0, spi_rx_q[1]}, 32'h02, "boot byte 1");
			compare_values({24'd0, spi_rx_q[2]}, 32'h03, "boot byte 2");
		end
		compare_values(valid_cycles, 0, "reply to boot command");
		tests++;
		if (errors != err_before)
			failed_tests++;
		$display("test %0d boot: %s", tests, (errors == err_before) ? "ok" : "mismatch");

		for (int l = 0; l < n_lines; l++)
			run_line(l);

		$display("%0d tests run, %0d with errors, %0d value errors",
			tests, failed_tests, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
